// File: Bender.yml
package:
  name: ssb_demod

sources:
  - include_dirs:
      - include
    files:
      - source/ssb_demod_pkg.sv
      - source/sample_framer.sv
      - source/dft8_engine.sv
      - source/ssb_symbol_tagger.sv
      - source/ssb_demod_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/tb_clock_gen.sv
      - tb/tb_ssb_demod.sv

// File: include/ssb_demod_macros.svh
`ifndef SSB_DEMOD_MACROS_SVH
`define SSB_DEMOD_MACROS_SVH

// useful samples per OFDM symbol
`define FFT_LEN 8

// cyclic prefix on symbols 1 to 3
`define CP_LEN 2

// symbols per SSB burst
`define SSB_LEN 4

// complex sample, real part in the upper half
`define SAMPLE_W 16

// complex bin, real part in the upper half
`define BIN_W 40

// signed twiddle component
`define TW_W 8

`endif

// File: source/dft8_engine.sv
`timescale 1ns/1ps

`include "ssb_demod_macros.svh"

module dft8_engine
    import ssb_demod_pkg::*;
(
    input  logic    clk_i,
    input  logic    reset_ni,
    input  sample_t sample_i,
    input  logic    sample_en_i,
    output bin_t    bin_o,
    output logic    bin_valid_o,
    output logic    bin_sync_o
);

    localparam int PART_W = `BIN_W / 2;

    logic signed [`SAMPLE_W/2-1:0] x_re, x_im;
    idx_t n_q;          // input sample index
    idx_t rd_idx_q;     // output bin index
    logic rd_active_q;
    logic last_w;
    bin_t bank_w [`FFT_LEN];

    // W[m] = 64 * exp(-j*2*pi*m/8), rounded
    function automatic twiddle_t tw_re(input idx_t m);
        case (m)
            3'd0:       tw_re = 8'sd64;
            3'd1, 3'd7: tw_re = 8'sd45;
            3'd2, 3'd6: tw_re = 8'sd0;
            3'd3, 3'd5: tw_re = -8'sd45;
            default:    tw_re = -8'sd64;
        endcase
    endfunction

    function automatic twiddle_t tw_im(input idx_t m);
        case (m)
            3'd0, 3'd4: tw_im = 8'sd0;
            3'd1, 3'd3: tw_im = -8'sd45;
            3'd2:       tw_im = -8'sd64;
            3'd5, 3'd7: tw_im = 8'sd45;
            default:    tw_im = 8'sd64;
        endcase
    endfunction

    assign x_re   = sample_i[`SAMPLE_W-1:`SAMPLE_W/2];
    assign x_im   = sample_i[`SAMPLE_W/2-1:0];
    assign last_w = (n_q == idx_t'(`FFT_LEN - 1));

    for (genvar k = 0; k < `FFT_LEN; k++) begin : g_mac
        idx_t                     m;
        twiddle_t                 w_re, w_im;
        logic signed [PART_W-1:0] p_re, p_im;
        logic signed [PART_W-1:0] acc_re, acc_im;
        bin_t                     bank_q;

        assign m    = idx_t'(k) * n_q;    // k*n mod 8
        assign w_re = tw_re(m);
        assign w_im = tw_im(m);
        assign p_re = x_re * w_re - x_im * w_im;
        assign p_im = x_re * w_im + x_im * w_re;

        always_ff @(posedge clk_i) begin
            if (!reset_ni) begin
                acc_re <= '0;
                acc_im <= '0;
            end else if (sample_en_i) begin
                if (last_w) begin
                    acc_re <= '0;
                    acc_im <= '0;
                end else begin
                    acc_re <= acc_re + p_re;
                    acc_im <= acc_im + p_im;
                end
            end
        end

        // second buffer, read out while the next symbol accumulates
        always_ff @(posedge clk_i) begin
            if (sample_en_i && last_w) begin
                bank_q <= {acc_re + p_re, acc_im + p_im};
            end
        end

        assign bank_w[k] = bank_q;
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            n_q         <= '0;
            rd_idx_q    <= '0;
            rd_active_q <= 1'b0;
        end else begin
            if (sample_en_i) begin
                n_q <= n_q + 1'b1;
            end
            if (sample_en_i && last_w) begin
                rd_active_q <= 1'b1;
                rd_idx_q    <= '0;
            end else if (rd_active_q) begin
                rd_idx_q <= rd_idx_q + 1'b1;
                if (rd_idx_q == idx_t'(`FFT_LEN - 1)) begin
                    rd_active_q <= 1'b0;
                end
            end
        end
    end

    assign bin_o       = bank_w[rd_idx_q];
    assign bin_valid_o = rd_active_q;
    assign bin_sync_o  = rd_active_q && (rd_idx_q == '0);

endmodule

// File: source/sample_framer.sv
`timescale 1ns/1ps

`include "ssb_demod_macros.svh"

module sample_framer
    import ssb_demod_pkg::*;
(
    input  logic    clk_i,
    input  logic    reset_ni,
    input  sample_t sample_i,
    input  logic    sample_valid_i,
    input  logic    ssb_start_i,
    output sample_t sample_o,
    output logic    sample_en_o
);

    framer_state_t state_q;
    idx_t          cnt_q;       // useful or cp sample count
    sym_cnt_t      sym_q;
    logic          take_w;

    // the sample that comes with the start pulse is already useful
    assign take_w = sample_valid_i &&
                    (state_q == FR_USEFUL || (state_q == FR_IDLE && ssb_start_i));

    always_ff @(posedge clk_i) begin
        sample_o <= sample_i;
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state_q     <= FR_IDLE;
            cnt_q       <= '0;
            sym_q       <= '0;
            sample_en_o <= 1'b0;
        end else begin
            sample_en_o <= take_w;
            case (state_q)
                FR_IDLE: begin
                    if (ssb_start_i) begin
                        state_q <= FR_USEFUL;
                        sym_q   <= '0;
                        cnt_q   <= take_w ? idx_t'(1) : '0;
                    end
                end
                FR_USEFUL: begin
                    if (sample_valid_i) begin
                        if (cnt_q == idx_t'(`FFT_LEN - 1)) begin
                            cnt_q <= '0;
                            if (sym_q == sym_cnt_t'(`SSB_LEN - 1)) begin
                                state_q <= FR_IDLE;   // burst done
                                sym_q   <= '0;
                            end else begin
                                state_q <= FR_SKIP_CP;
                                sym_q   <= sym_q + 1'b1;
                            end
                        end else begin
                            cnt_q <= cnt_q + 1'b1;
                        end
                    end
                end
                FR_SKIP_CP: begin
                    if (sample_valid_i) begin
                        if (cnt_q == idx_t'(`CP_LEN - 1)) begin
                            cnt_q   <= '0;
                            state_q <= FR_USEFUL;
                        end else begin
                            cnt_q <= cnt_q + 1'b1;
                        end
                    end
                end
                default: state_q <= FR_IDLE;
            endcase
        end
    end

endmodule

// File: source/ssb_demod_pkg.sv
package ssb_demod_pkg;

`include "ssb_demod_macros.svh"

    typedef logic [`SAMPLE_W-1:0] sample_t;              // {re, im}
    typedef logic [`BIN_W-1:0] bin_t;                    // {re, im}
    typedef logic signed [`TW_W-1:0] twiddle_t;
    typedef logic [$clog2(`FFT_LEN)-1:0] idx_t;          // sample or bin index
    typedef logic [$clog2(`SSB_LEN)-1:0] sym_cnt_t;      // symbol within burst

    typedef enum logic [1:0] {
        FR_IDLE,
        FR_USEFUL,
        FR_SKIP_CP
    } framer_state_t;

    typedef enum logic [1:0] {
        TG_IDLE,
        TG_WAIT_SYNC,
        TG_OUTPUT
    } tagger_state_t;

endpackage

// File: source/ssb_demod_top.sv
`timescale 1ns/1ps

module ssb_demod_top
    import ssb_demod_pkg::*;
(
    input  logic    clk_i,
    input  logic    reset_ni,
    input  sample_t sample_i,
    input  logic    sample_valid_i,
    input  logic    ssb_start_i,
    output bin_t    data_o,
    output logic    data_valid_o,
    output logic    pbch_valid_o,
    output logic    sss_valid_o,
    output logic    pbch_start_o,
    output logic    sss_start_o,
    output logic    symbol_start_o
);

    sample_t sample_q;
    logic    sample_en;
    bin_t    bin_data;
    logic    bin_valid;
    logic    bin_sync;      // with bin 0 of each symbol

    sample_framer sample_framer_inst (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .sample_i       (sample_i),
        .sample_valid_i (sample_valid_i),
        .ssb_start_i    (ssb_start_i),
        .sample_o       (sample_q),
        .sample_en_o    (sample_en)
    );

    dft8_engine dft8_engine_inst (
        .clk_i       (clk_i),
        .reset_ni    (reset_ni),
        .sample_i    (sample_q),
        .sample_en_i (sample_en),
        .bin_o       (bin_data),
        .bin_valid_o (bin_valid),
        .bin_sync_o  (bin_sync)
    );

    ssb_symbol_tagger ssb_symbol_tagger_inst (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .ssb_start_i    (ssb_start_i),
        .bin_i          (bin_data),
        .bin_valid_i    (bin_valid),
        .bin_sync_i     (bin_sync),
        .data_o         (data_o),
        .data_valid_o   (data_valid_o),
        .pbch_valid_o   (pbch_valid_o),
        .sss_valid_o    (sss_valid_o),
        .pbch_start_o   (pbch_start_o),
        .sss_start_o    (sss_start_o),
        .symbol_start_o (symbol_start_o)
    );

endmodule

// File: source/ssb_symbol_tagger.sv
`timescale 1ns/1ps

`include "ssb_demod_macros.svh"

module ssb_symbol_tagger
    import ssb_demod_pkg::*;
(
    input  logic clk_i,
    input  logic reset_ni,
    input  logic ssb_start_i,
    input  bin_t bin_i,
    input  logic bin_valid_i,
    input  logic bin_sync_i,
    output bin_t data_o,
    output logic data_valid_o,
    output logic pbch_valid_o,
    output logic sss_valid_o,
    output logic pbch_start_o,
    output logic sss_start_o,
    output logic symbol_start_o
);

    tagger_state_t state_q;
    idx_t          bin_cnt_q;
    sym_cnt_t      sym_q;
    logic          start_pend_q;    // next burst began during output
    logic          accept_w;
    bin_t          data_q;
    logic          valid_q;
    logic          sync_q;
    sym_cnt_t      sym_d1_q;

    assign accept_w = bin_valid_i &&
                      ((state_q == TG_WAIT_SYNC && bin_sync_i) || state_q == TG_OUTPUT);

    always_ff @(posedge clk_i) begin
        data_q <= bin_i;
        data_o <= data_q;
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state_q      <= TG_IDLE;
            bin_cnt_q    <= '0;
            sym_q        <= '0;
            start_pend_q <= 1'b0;
        end else begin
            if (ssb_start_i && state_q != TG_IDLE) begin
                start_pend_q <= 1'b1;
            end
            case (state_q)
                TG_IDLE: begin
                    sym_q <= '0;
                    if (ssb_start_i) state_q <= TG_WAIT_SYNC;
                end
                TG_WAIT_SYNC: begin
                    if (accept_w) begin
                        state_q   <= TG_OUTPUT;
                        bin_cnt_q <= idx_t'(1);
                    end
                end
                TG_OUTPUT: begin
                    bin_cnt_q <= bin_cnt_q + 1'b1;
                    if (bin_cnt_q == idx_t'(`FFT_LEN - 1)) begin
                        sym_q <= sym_q + 1'b1;
                        if (sym_q != sym_cnt_t'(`SSB_LEN - 1)) begin
                            state_q <= TG_WAIT_SYNC;
                        end else if (start_pend_q || ssb_start_i) begin
                            state_q      <= TG_WAIT_SYNC;   // back-to-back burst
                            start_pend_q <= 1'b0;
                        end else begin
                            state_q <= TG_IDLE;
                        end
                    end
                end
                default: state_q <= TG_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            valid_q        <= 1'b0;
            sync_q         <= 1'b0;
            sym_d1_q       <= '0;
            data_valid_o   <= 1'b0;
            pbch_valid_o   <= 1'b0;
            sss_valid_o    <= 1'b0;
            pbch_start_o   <= 1'b0;
            sss_start_o    <= 1'b0;
            symbol_start_o <= 1'b0;
        end else begin
            valid_q  <= accept_w;
            sync_q   <= accept_w && state_q == TG_WAIT_SYNC;
            sym_d1_q <= sym_q;

            // symbol 3 carries data but no channel flag
            data_valid_o   <= valid_q;
            pbch_valid_o   <= valid_q && (sym_d1_q == 2'd0 || sym_d1_q == 2'd2);
            sss_valid_o    <= valid_q && (sym_d1_q == 2'd1);
            symbol_start_o <= sync_q;
            pbch_start_o   <= sync_q && (sym_d1_q == 2'd0);
            sss_start_o    <= sync_q && (sym_d1_q == 2'd1);
        end
    end

endmodule

// File: tb/ssb_demod_testdata.txt
// per symbol: one line of input samples {re8,im8}, then one line of 8 expected bins {re20,im20}
// symbol 0 holds 8 useful samples; symbols 1 to 3 hold 2 cp samples, then 8 useful
// burst 0 symbol 0: constant (3,-2)
03FE 03FE 03FE 03FE 03FE 03FE 03FE 03FE
00600FFC00 0000000000 0000000000 0000000000 0000000000 0000000000 0000000000 0000000000
// burst 0 symbol 1: impulse (5,3) at n=0
0000 0000 0503 0000 0000 0000 0000 0000 0000 0000
00140000C0 00140000C0 00140000C0 00140000C0 00140000C0 00140000C0 00140000C0 00140000C0
// burst 0 symbol 2: impulse (2,0) at n=1
0000 0000 0000 0200 0000 0000 0000 0000 0000 0000
0008000000 0005AFFFA6 00000FFF80 FFFA6FFFA6 FFF8000000 FFFA60005A 0000000080 0005A0005A
// burst 0 symbol 3: impulse (1,1) at n=7
0000 0101 0000 0000 0000 0000 0000 0000 0000 0101
0004000040 000000005A FFFC000040 FFFA600000 FFFC0FFFC0 00000FFFA6 00040FFFC0 0005A00000
// burst 1 symbol 0: constant (-4,1)
FC01 FC01 FC01 FC01 FC01 FC01 FC01 FC01
FF80000200 0000000000 0000000000 0000000000 0000000000 0000000000 0000000000 0000000000
// burst 1 symbol 1: impulse (-7,-8) at n=0
0000 0000 F9F8 0000 0000 0000 0000 0000 0000 0000
FFE40FFE00 FFE40FFE00 FFE40FFE00 FFE40FFE00 FFE40FFE00 FFE40FFE00 FFE40FFE00 FFE40FFE00
// burst 1 symbol 2: impulse (0,3) at n=1
0000 0000 0000 0003 0000 0000 0000 0000 0000 0000
00000000C0 0008700087 000C000000 00087FFF79 00000FFF40 FFF79FFF79 FFF4000000 FFF7900087
// burst 1 symbol 3: constant (2,2)
0202 0202 0202 0202 0202 0202 0202 0202 0202 0202
0040000400 0000000000 0000000000 0000000000 0000000000 0000000000 0000000000 0000000000

// File: tb/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk_o,
    output logic reset_no
);

    localparam int HALF_PERIOD = 10;    // 20 ns clock
    localparam int RESET_CYCLES = 5;

    initial begin
        clk_o = 1'b0;
        forever #HALF_PERIOD clk_o = ~clk_o;
    end

    initial begin
        reset_no = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        reset_no <= 1'b1;
    end

endmodule

// File: tb/tb_ssb_demod.sv
`timescale 1ns/1ps

`include "ssb_demod_macros.svh"

module tb_ssb_demod
    import ssb_demod_pkg::*;
();

    localparam int BURSTS = 2;
    localparam int MAX_GAP = 2;             // longest run of invalid cycles
    localparam int IDLE_GAP = 16;           // quiet cycles after each burst
    localparam int DRAIN_CYCLES = 24;
    localparam int IN_PER_BURST = `FFT_LEN + (`SSB_LEN - 1) * (`FFT_LEN + `CP_LEN);
    localparam int MEM_WORDS = BURSTS * (IN_PER_BURST + `SSB_LEN * `FFT_LEN);
    localparam int TOTAL_BINS = BURSTS * `SSB_LEN * `FFT_LEN;
    localparam int IN_CYCLES = BURSTS * (IN_PER_BURST * (1 + MAX_GAP) + IDLE_GAP);
    localparam int TIMEOUT_CYCLES = 4 * IN_CYCLES + 100;

    logic    clk;
    logic    reset_n;
    sample_t sample;
    logic    sample_valid;
    logic    ssb_start;
    bin_t    data;
    logic    data_valid;
    logic    pbch_valid;
    logic    sss_valid;
    logic    pbch_start;
    logic    sss_start;
    logic    symbol_start;

    bin_t     test_mem [MEM_WORDS];
    bin_t     exp_bin_q [$];
    sym_cnt_t exp_sym_q [$];
    idx_t     exp_idx_q [$];
    bin_t     exp_bin;
    sym_cnt_t exp_sym;
    idx_t     exp_idx;
    string    where;
    integer   seed;
    int       bin_errors = 0;
    int       flag_errors = 0;
    int       other_errors = 0;
    int       rx_count = 0;
    int       symbols_seen = 0;
    int       valid_run = 0;      // length of the current data_valid_o run
    int       cycle_cnt = 0;

    tb_clock_gen tb_clock_gen_inst (
        .clk_o    (clk),
        .reset_no (reset_n)
    );

    ssb_demod_top ssb_demod_top_inst (
        .clk_i          (clk),
        .reset_ni       (reset_n),
        .sample_i       (sample),
        .sample_valid_i (sample_valid),
        .ssb_start_i    (ssb_start),
        .data_o         (data),
        .data_valid_o   (data_valid),
        .pbch_valid_o   (pbch_valid),
        .sss_valid_o    (sss_valid),
        .pbch_start_o   (pbch_start),
        .sss_start_o    (sss_start),
        .symbol_start_o (symbol_start)
    );

    task automatic check_bin(input bin_t got, input bin_t exp, input string what);
        if (got !== exp) begin
            bin_errors++;
            $display("MISMATCH at %0t ns: %s data_o got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            flag_errors++;
            $display("MISMATCH at %0t ns: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic drive_sample(input sample_t s, input logic start);
        @(posedge clk);
        sample       <= s;
        sample_valid <= 1'b1;
        ssb_start    <= start;
    endtask

    task automatic drive_idle(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            sample       <= sample_t'(16'h7f7f);   // never taken
            sample_valid <= 1'b0;
            ssb_start    <= 1'b0;
        end
    endtask

    // start pulse rides on the first useful sample of symbol 0
    task automatic drive_bursts();
        int ptr;
        int n_in;
        int gap;
        ptr = 0;
        for (int b = 0; b < BURSTS; b++) begin
            for (int s = 0; s < `SSB_LEN; s++) begin
                n_in = (s == 0) ? `FFT_LEN : `FFT_LEN + `CP_LEN;
                for (int i = 0; i < n_in; i++) begin
                    if (s != 0 || i != 0) begin
                        gap = ($random(seed) & 32'h7fff_ffff) % (MAX_GAP + 1);
                        drive_idle(gap);
                    end
                    drive_sample(sample_t'(test_mem[ptr]), s == 0 && i == 0);
                    ptr++;
                end
                for (int k = 0; k < `FFT_LEN; k++) begin
                    exp_bin_q.push_back(test_mem[ptr]);
                    exp_sym_q.push_back(sym_cnt_t'(s));
                    exp_idx_q.push_back(idx_t'(k));
                    ptr++;
                end
            end
            drive_idle(IDLE_GAP);
        end
    endtask

    always @(negedge clk) begin
        if (reset_n === 1'b1) begin
            if (data_valid === 1'b1) begin
                rx_count++;
                valid_run++;
                if (exp_bin_q.size() == 0) begin
                    other_errors++;
                    $display("unexpected valid output at %0t ns with no symbol pending", $time);
                end else begin
                    exp_bin = exp_bin_q.pop_front();
                    exp_sym = exp_sym_q.pop_front();
                    exp_idx = exp_idx_q.pop_front();
                    where = $sformatf("symbol %0d bin %0d", exp_sym, exp_idx);
                    check_bin(data, exp_bin, where);
                    check_flag(pbch_valid, exp_sym == 0 || exp_sym == 2, {where, " pbch_valid_o"});
                    check_flag(sss_valid, exp_sym == 1, {where, " sss_valid_o"});
                    check_flag(symbol_start, exp_idx == 0, {where, " symbol_start_o"});
                    check_flag(pbch_start, exp_idx == 0 && exp_sym == 0, {where, " pbch_start_o"});
                    check_flag(sss_start, exp_idx == 0 && exp_sym == 1, {where, " sss_start_o"});
                end
            end else begin
                if (valid_run != 0) begin
                    symbols_seen++;
                    if (valid_run != `FFT_LEN) begin
                        other_errors++;
                        $display("output symbol ending at %0t ns had %0d valid cycles instead of %0d",
                                 $time, valid_run, `FFT_LEN);
                    end
                    valid_run = 0;
                end
                check_flag(pbch_valid, 1'b0, "idle pbch_valid_o");
                check_flag(sss_valid, 1'b0, "idle sss_valid_o");
                check_flag(symbol_start, 1'b0, "idle symbol_start_o");
                check_flag(pbch_start, 1'b0, "idle pbch_start_o");
                check_flag(sss_start, 1'b0, "idle sss_start_o");
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > TIMEOUT_CYCLES) begin
            other_errors++;
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("errors: %0d bin, %0d flag, %0d other", bin_errors, flag_errors, other_errors);
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        sample = '0;
        sample_valid = 1'b0;
        ssb_start = 1'b0;
        seed = 38;
        $readmemh("tb/ssb_demod_testdata.txt", test_mem);
        if ($isunknown(test_mem[MEM_WORDS - 1])) begin
            other_errors++;
            $display("test data file could not be read completely");
        end else begin
            wait (reset_n === 1'b1);
            drive_idle(4);
            drive_bursts();
            while (rx_count < TOTAL_BINS) begin
                @(posedge clk);
            end
            drive_idle(DRAIN_CYCLES);   // late valids show up as errors
        end
        if (exp_bin_q.size() != 0) begin
            other_errors++;
            $display("%0d expected bins never reached the output", exp_bin_q.size());
        end
        if (symbols_seen != BURSTS * `SSB_LEN) begin
            other_errors++;
            $display("saw %0d output symbols instead of %0d", symbols_seen, BURSTS * `SSB_LEN);
        end
        $display("errors: %0d bin, %0d flag, %0d other", bin_errors, flag_errors, other_errors);
        if (bin_errors + flag_errors + other_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+include
source/ssb_demod_pkg.sv
source/sample_framer.sv
source/dft8_engine.sv
source/ssb_symbol_tagger.sv
source/ssb_demod_top.sv
tb/tb_clock_gen.sv
tb/tb_ssb_demod.sv
